//--- src/lsu_pkg.sv
// shared types and sizes for the load/store unit, referenced by scoped name from every block
package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W = 32;              // data and address width
  localparam int BE_W   = DATA_W / 8;      // one enable per byte lane
  localparam int OFFS_W = $clog2(BE_W);    // byte offset inside a word

  ////////////////////////////////////////////////////////////
  // access size
  ////////////////////////////////////////////////////////////

  // encoding kept from the core's execute stage: 2 and 3 both mean byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  ////////////////////////////////////////////////////////////
  // sequencer states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE        = 3'd0,   // waiting for a strobe
    WAIT_GNT    = 3'd1,   // request out, waiting for the grant
    WAIT_RVALID = 3'd2    // granted, response due next cycle
  } lsu_state_e;

endpackage

//--- src/lsu_ctl_if.sv
// control bundle between the access sequencer and the two datapath blocks of the unit
`timescale 1ns/100ps

interface lsu_ctl_if;

  logic accept;       // 1-cycle pulse, access taken this cycle
  logic second;       // level, second part of a split access in flight
  logic latch_first;  // 1-cycle pulse, first part response present
  logic misaligned;   // level, registered access crosses a word

  // sequencer drives the phase, reads the split decision
  modport ctrl (
    output accept,
    output second,
    output latch_first,
    input  misaligned
  );

  // request formatter
  modport store (
    input  accept,
    input  second,
    output misaligned
  );

  // load data aligner
  modport load (
    input  accept,
    input  second,
    input  latch_first
  );

endinterface

//--- src/lsu_ctrl.sv
// access sequencer of the load/store unit, runs one or two memory transactions per strobe
`timescale 1ns/100ps

module lsu_ctrl (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      lsu_req_i,      // access strobe from execute
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  output logic      data_req_o,
  output logic      lsu_done_o,     // 1-cycle, result ready
  output logic      lsu_busy_o,
  lsu_ctl_if.ctrl   ctl
);

  lsu_pkg::lsu_state_e state_q, state_d;

  logic second_q, second_d;   // tracks which part of a split access is out

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d         = state_q;
    second_d        = second_q;
    data_req_o      = 1'b0;
    lsu_done_o      = 1'b0;
    ctl.accept      = 1'b0;
    ctl.latch_first = 1'b0;

    case (state_q)
      lsu_pkg::IDLE:
      begin
        if (lsu_req_i)
        begin
          ctl.accept = 1'b1;             // formatter and aligner capture now
          second_d   = 1'b0;
          state_d    = lsu_pkg::WAIT_GNT;
        end
      end

      lsu_pkg::WAIT_GNT:
      begin
        data_req_o = 1'b1;               // held until granted
        if (data_gnt_i)
          state_d = lsu_pkg::WAIT_RVALID;
      end

      lsu_pkg::WAIT_RVALID:
      begin
        if (data_rvalid_i)
        begin
          if (ctl.misaligned && !second_q)
          begin
            // first half back, go again at the next word
            ctl.latch_first = 1'b1;
            second_d        = 1'b1;
            state_d         = lsu_pkg::WAIT_GNT;
          end
          else
          begin
            lsu_done_o = 1'b1;
            second_d   = 1'b0;
            state_d    = lsu_pkg::IDLE;
          end
        end
      end

      default:
      begin
        second_d = 1'b0;
        state_d  = lsu_pkg::IDLE;       // unused encodings recover
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= lsu_pkg::IDLE;
      second_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      second_q <= second_d;
    end
  end

  assign ctl.second = second_q;
  assign lsu_busy_o = (state_q != lsu_pkg::IDLE);  // high T+1 through done

endmodule

//--- src/lsu_store_fmt.sv
// request formatter: registers the accepted access and forms address, byte enables and write data
`timescale 1ns/100ps

module lsu_store_fmt (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lsu_we_i,
  input  lsu_pkg::lsu_type_e           lsu_type_i,
  input  logic [lsu_pkg::DATA_W-1:0]   lsu_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]   lsu_wdata_i,
  output logic [lsu_pkg::DATA_W-1:0]   data_addr_o,
  output logic                         data_we_o,
  output logic [lsu_pkg::BE_W-1:0]     data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]   data_wdata_o,
  lsu_ctl_if.store                     ctl
);

  logic                         we_q;
  lsu_pkg::lsu_type_e           type_q;
  logic [lsu_pkg::DATA_W-1:0]   addr_q;
  logic [lsu_pkg::DATA_W-1:0]   wdata_q;
  logic [lsu_pkg::OFFS_W-1:0]   offs;
  logic [lsu_pkg::DATA_W-1:0]   addr_base;

  // access captured on accept, stable for the whole request
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      we_q   <= 1'b0;
      type_q <= lsu_pkg::LSU_WORD;
    end
    else if (ctl.accept)
    begin
      we_q   <= lsu_we_i;
      type_q <= lsu_type_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctl.accept)
    begin
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign offs      = addr_q[lsu_pkg::OFFS_W-1:0];
  assign addr_base = {addr_q[lsu_pkg::DATA_W-1:lsu_pkg::OFFS_W], {lsu_pkg::OFFS_W{1'b0}}};

  ////////////////////////////////////////////////////////////
  // address, enables, lanes
  ////////////////////////////////////////////////////////////

  assign data_addr_o = ctl.second ? addr_base + lsu_pkg::DATA_W'(lsu_pkg::BE_W) : addr_base;
  assign data_we_o   = we_q;

  always_comb
  begin
    case (type_q)
      lsu_pkg::LSU_WORD:
      begin
        if (!ctl.second)
          data_be_o = 4'b1111 << offs;          // offset and up
        else
          data_be_o = ~(4'b1111 << offs);       // low bytes that spilled over
      end
      lsu_pkg::LSU_HALF:
      begin
        case ({ctl.second, offs})
          3'b0_00: data_be_o = 4'b0011;
          3'b0_01: data_be_o = 4'b0110;
          3'b0_10: data_be_o = 4'b1100;
          3'b0_11: data_be_o = 4'b1000;       // upper byte goes in part two
          default: data_be_o = 4'b0001;
        endcase
      end
      default: data_be_o = 4'b0001 << offs;     // byte, never split
    endcase
  end

  // rotate left by offset so store byte k sits in lane (offset+k) mod 4
  always_comb
  begin
    case (offs)
      2'd0:    data_wdata_o = wdata_q;
      2'd1:    data_wdata_o = {wdata_q[23:0], wdata_q[31:24]};
      2'd2:    data_wdata_o = {wdata_q[15:0], wdata_q[31:16]};
      default: data_wdata_o = {wdata_q[7:0],  wdata_q[31:8]};
    endcase
  end

  // word off a boundary, or half straddling lanes 3 and 0
  assign ctl.misaligned = ((type_q == lsu_pkg::LSU_WORD) && (offs != 2'd0)) ||
                          ((type_q == lsu_pkg::LSU_HALF) && (offs == 2'd3));

endmodule

//--- src/lsu_load_align.sv
// load data aligner: joins split responses, picks the field and extends it to a full word
`timescale 1ns/100ps

module lsu_load_align (
  input  logic                         clk,
  input  logic                         rst_n,
  input  lsu_pkg::lsu_type_e           lsu_type_i,
  input  logic                         lsu_sign_ext_i,
  input  logic [lsu_pkg::DATA_W-1:0]   lsu_addr_i,     // only the offset is kept
  input  logic [lsu_pkg::DATA_W-1:0]   data_rdata_i,
  input  logic                         data_rvalid_i,
  output logic [lsu_pkg::DATA_W-1:0]   lsu_rdata_o,
  lsu_ctl_if.load                      ctl
);

  lsu_pkg::lsu_type_e             type_q;
  logic [lsu_pkg::OFFS_W-1:0]     offs_q;
  logic                           sign_q;

  logic [lsu_pkg::DATA_W-1:0]     first_q;   // part one response of a split load
  logic [lsu_pkg::DATA_W-1:0]     rdata_q;   // last result, held between loads

  logic [2*lsu_pkg::DATA_W-1:0]   rd_window;
  logic [2*lsu_pkg::DATA_W-1:0]   rd_shift;
  logic [lsu_pkg::DATA_W-1:0]     field;
  logic [lsu_pkg::DATA_W-1:0]     result;
  logic                           final_rvalid;

  ////////////////////////////////////////////////////////////
  // load attributes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q <= lsu_pkg::LSU_WORD;
      offs_q <= '0;
      sign_q <= 1'b0;
    end
    else if (ctl.accept)
    begin
      type_q <= lsu_type_i;
      offs_q <= lsu_addr_i[lsu_pkg::OFFS_W-1:0];
      sign_q <= lsu_sign_ext_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctl.latch_first)
      first_q <= data_rdata_i;
  end

  ////////////////////////////////////////////////////////////
  // field select and extension
  ////////////////////////////////////////////////////////////

  // second word on top, so a plain right shift walks across the boundary
  assign rd_window = ctl.second ? {data_rdata_i, first_q}
                                : {{lsu_pkg::DATA_W{1'b0}}, data_rdata_i};
  assign rd_shift  = rd_window >> {offs_q, 3'b000};
  assign field     = rd_shift[lsu_pkg::DATA_W-1:0];

  always_comb
  begin
    case (type_q)
      lsu_pkg::LSU_WORD:
        result = field;
      lsu_pkg::LSU_HALF:
        result = {{(lsu_pkg::DATA_W-16){sign_q & field[15]}}, field[15:0]};
      default:  // byte, type 2 or 3
        result = {{(lsu_pkg::DATA_W-8){sign_q & field[7]}}, field[7:0]};
    endcase
  end

  // last response of the access, done is high in the same cycle
  assign final_rvalid = data_rvalid_i && !ctl.latch_first;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (final_rvalid)
      rdata_q <= result;
  end

  // live value in the done cycle, held copy afterwards
  assign lsu_rdata_o = final_rvalid ? result : rdata_q;

endmodule

//--- src/lsu_top.sv
// load/store unit top level, connects sequencer, request formatter and load aligner to the ports
`timescale 1ns/100ps

module lsu_top (
  input  logic                         clk,
  input  logic                         rst_n,

  ////////////////////////////////////////////////////////////
  // execute stage side
  ////////////////////////////////////////////////////////////
  input  logic                         lsu_req_i,
  input  logic                         lsu_we_i,
  input  lsu_pkg::lsu_type_e           lsu_type_i,
  input  logic                         lsu_sign_ext_i,
  input  logic [lsu_pkg::DATA_W-1:0]   lsu_addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]   lsu_wdata_i,
  output logic [lsu_pkg::DATA_W-1:0]   lsu_rdata_o,
  output logic                         lsu_done_o,
  output logic                         lsu_busy_o,

  ////////////////////////////////////////////////////////////
  // data memory side
  ////////////////////////////////////////////////////////////
  output logic                         data_req_o,
  input  logic                         data_gnt_i,
  input  logic                         data_rvalid_i,
  output logic [lsu_pkg::DATA_W-1:0]   data_addr_o,
  output logic                         data_we_o,
  output logic [lsu_pkg::BE_W-1:0]     data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]   data_wdata_o,
  input  logic [lsu_pkg::DATA_W-1:0]   data_rdata_i
);

  lsu_ctl_if ctl_if ();   // phase and capture strobes

  lsu_ctrl lsu_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_req_i     (lsu_req_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .lsu_done_o    (lsu_done_o),
    .lsu_busy_o    (lsu_busy_o),
    .ctl           (ctl_if.ctrl)
  );

  lsu_store_fmt lsu_store_fmt_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_we_i     (lsu_we_i),
    .lsu_type_i   (lsu_type_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .data_addr_o  (data_addr_o),
    .data_we_o    (data_we_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .ctl          (ctl_if.store)
  );

  lsu_load_align lsu_load_align_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_addr_i     (lsu_addr_i),
    .data_rdata_i   (data_rdata_i),
    .data_rvalid_i  (data_rvalid_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .ctl            (ctl_if.load)
  );

endmodule

//--- sim/lsu_checker.sv
// protocol assertions for the load/store unit, bound into the top level by the testbench
`timescale 1ns/100ps

module lsu_checker (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         lsu_req_i,
  input logic                         lsu_busy_o,
  input logic                         lsu_done_o,
  input logic                         data_req_o,
  input logic                         data_gnt_i,
  input logic                         data_rvalid_i,
  input logic                         data_we_o,
  input logic [lsu_pkg::DATA_W-1:0]   data_addr_o,
  input logic [lsu_pkg::BE_W-1:0]     data_be_o,
  input logic [lsu_pkg::DATA_W-1:0]   data_wdata_o,
  input lsu_pkg::lsu_state_e          state_i       // sequencer state
);

  int fail_cnt = 0;   // failed properties so far

  // ungranted request stays up, fields frozen
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_be_o) &&
                                  $stable(data_we_o) && $stable(data_wdata_o))
    else
    begin
      fail_cnt++;
      $error("memory request dropped or changed before its grant");
    end

  done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_done_o |-> lsu_busy_o)
    else
    begin
      fail_cnt++;
      $error("done pulsed while the unit was idle");
    end

  no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_busy_o |-> !lsu_req_i)
    else
    begin
      fail_cnt++;
      $error("access strobe while the unit was busy");
    end

  // a response the sequencer is not waiting for would be lost
  rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> state_i == lsu_pkg::WAIT_RVALID)
    else
    begin
      fail_cnt++;
      $error("memory response arrived outside the response wait state");
    end

endmodule

//--- sim/lsu_tb.sv
// testbench for the load/store unit, runs directed and random accesses against a memory model
`timescale 1ns/100ps

module lsu_tb;

  localparam int N_ACCESSES  = 57;                        // 27 directed, 30 random
  localparam int CYCLE_LIMIT = N_ACCESSES * 12 + 4 + 10;  // two parts, 3 wait cycles each

  logic                         clk;
  logic                         rst_n;
  logic                         lsu_req_i;
  logic                         lsu_we_i;
  lsu_pkg::lsu_type_e           lsu_type_i;
  logic                         lsu_sign_ext_i;
  logic [lsu_pkg::DATA_W-1:0]   lsu_addr_i;
  logic [lsu_pkg::DATA_W-1:0]   lsu_wdata_i;
  logic [lsu_pkg::DATA_W-1:0]   lsu_rdata_o;
  logic                         lsu_done_o;
  logic                         lsu_busy_o;
  logic                         data_req_o;
  logic                         data_gnt_i;
  logic                         data_rvalid_i;
  logic [lsu_pkg::DATA_W-1:0]   data_addr_o;
  logic                         data_we_o;
  logic [lsu_pkg::BE_W-1:0]     data_be_o;
  logic [lsu_pkg::DATA_W-1:0]   data_wdata_o;
  logic [lsu_pkg::DATA_W-1:0]   data_rdata_i;

  logic [lsu_pkg::DATA_W-1:0]   mem [0:15];           // memory model, 16 words
  logic [7:0]                   shadow [0:63];        // reference bytes
  logic [31:0]                  rng_state = 32'hc61c;
  int                           gnt_wait  = 0;        // cycles before the next grant
  int                           gnt_cnt   = 0;        // handshakes of the current access
  int                           issued    = 0;
  int                           done_cnt  = 0;
  int                           cycles    = 0;

  // current access, reference side
  string                        cur_name;
  logic                         cur_load;
  lsu_pkg::lsu_type_e           cur_type;
  logic [lsu_pkg::DATA_W-1:0]   cur_addr;
  logic [lsu_pkg::DATA_W-1:0]   cur_exp;
  int                           cur_parts;

  lsu_top lsu_top_inst (.*);

  bind lsu_top lsu_checker lsu_checker_inst (
    .clk (clk), .rst_n (rst_n), .lsu_req_i (lsu_req_i), .lsu_busy_o (lsu_busy_o),
    .lsu_done_o (lsu_done_o), .data_req_o (data_req_o), .data_gnt_i (data_gnt_i),
    .data_rvalid_i (data_rvalid_i), .data_we_o (data_we_o), .data_addr_o (data_addr_o),
    .data_be_o (data_be_o), .data_wdata_o (data_wdata_o),
    .state_i (lsu_ctrl_inst.state_q)
  );

  assign data_gnt_i = data_req_o && (gnt_wait == 0);  // zero wait grants in the same cycle

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [7:0] fill_byte(input int b);
    return 8'(b * 37 + 91);  // odd step, every byte address distinct
  endfunction

  function automatic int size_of(input lsu_pkg::lsu_type_e ty);
    case (ty)
      lsu_pkg::LSU_WORD: return 4;
      lsu_pkg::LSU_HALF: return 2;
      default:           return 1;  // 2 and 3
    endcase
  endfunction

  // bytes offs..offs+n-1 laid over two words, high word is part two
  function automatic logic [3:0] expected_be(input lsu_pkg::lsu_type_e ty, input logic [1:0] offs,
                                             input logic second_part);
    logic [7:0] span;
    span = ((8'h01 << size_of(ty)) - 8'h01) << offs;
    return second_part ? span[7:4] : span[3:0];
  endfunction

  function automatic void ref_store(input logic [31:0] addr, input lsu_pkg::lsu_type_e ty,
                                    input logic [31:0] wdata);
    int k;
    for (k = 0; k < size_of(ty); k++)
      shadow[6'(addr[5:0] + k[5:0])] = wdata[8*k +: 8];  // wraps like the memory index
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] addr, input lsu_pkg::lsu_type_e ty,
                                           input logic sx);
    int          k;
    int          n;
    logic [31:0] v;
    n = size_of(ty);
    v = '0;
    for (k = 0; k < n; k++)
      v[8*k +: 8] = shadow[6'(addr[5:0] + k[5:0])];
    for (k = n; k < 4; k++)
      v[8*k +: 8] = {8{sx & v[8*n-1]}};  // extend from the top loaded bit
    return v;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rdata(input string name, input logic [lsu_pkg::DATA_W-1:0] exp, act);
    if (act !== exp)
      stop_on_error($sformatf("mismatch %s rdata: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input logic [lsu_pkg::DATA_W-1:0] exp, act);
    if (act !== exp)
      stop_on_error($sformatf("mismatch %s address: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_be(input string name, input logic [lsu_pkg::BE_W-1:0] exp, act);
    if (act !== exp)
      stop_on_error($sformatf("mismatch %s byte enables: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_misaligned_split(input string name, input int exp, act);
    if (act != exp)
      stop_on_error($sformatf("mismatch %s requests: expected %0d, actual %0d", name, exp, act));
  endtask

  // one strobe, then wait until the compare side has seen done
  task automatic run_access(input string name, input logic we, input lsu_pkg::lsu_type_e ty,
                            input logic sx, input logic [31:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    #2;
    cur_name  = name;
    cur_load  = !we;
    cur_type  = ty;
    cur_addr  = addr;
    cur_parts = (addr[1:0] + size_of(ty) > 4) ? 2 : 1;  // crosses a word boundary
    if (we)
      ref_store(addr, ty, wdata);
    else
      cur_exp = ref_load(addr, ty, sx);
    gnt_cnt        = 0;
    issued++;
    lsu_req_i      = 1'b1;
    lsu_we_i       = we;
    lsu_type_i     = ty;
    lsu_sign_ext_i = sx;
    lsu_addr_i     = addr;
    lsu_wdata_i    = wdata;
    @(posedge clk);
    #2;
    lsu_req_i = 1'b0;
    wait (done_cnt == issued);
  endtask

  ////////////////////////////////////////////////////////////
  // memory model, compare and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin : memory_model
    logic                       hs;
    logic                       stalled;
    logic [lsu_pkg::DATA_W-1:0] rd_word;
    int                         new_wait;
    int                         lane;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    new_wait      = 0;
    forever
    begin
      @(negedge clk);                                   // DUT outputs settled
      hs      = data_req_o && data_gnt_i;
      stalled = data_req_o && !data_gnt_i;
      rd_word = mem[data_addr_o[5:2]];                  // read before any write
      if (hs)
      begin
        check_addr(cur_name, {cur_addr[31:2], 2'b00} + 32'(4 * gnt_cnt), data_addr_o);
        check_be(cur_name, expected_be(cur_type, cur_addr[1:0], gnt_cnt == 1), data_be_o);
        gnt_cnt++;
        if (data_we_o)
          for (lane = 0; lane < 4; lane++)
            if (data_be_o[lane])
              mem[data_addr_o[5:2]][8*lane +: 8] = data_wdata_o[8*lane +: 8];
        new_wait = int'(next_rand() & 32'd3);            // 0..3 for the next request
      end
      @(posedge clk);
      #2;
      data_rvalid_i = hs;                               // response one cycle after grant
      data_rdata_i  = rd_word;
      if (hs)
        gnt_wait = new_wait;
      else if (stalled && gnt_wait > 0)
        gnt_wait--;
    end
  end

  always @(negedge clk)
  begin : compare
    if (rst_n && lsu_done_o)
    begin
      if (done_cnt >= issued)
        stop_on_error("done pulsed with no access outstanding");
      else
      begin
        check_misaligned_split(cur_name, cur_parts, gnt_cnt);
        if (cur_load)
          check_rdata(cur_name, cur_exp, lsu_rdata_o);
        done_cnt++;
      end
    end
  end

  // bound protocol properties, stop at the first failure
  always @(negedge clk)
  begin : assertion_watch
    if (lsu_top_inst.lsu_checker_inst.fail_cnt != 0)
      stop_on_error("a protocol assertion in the bound checker failed");
  end

  always @(posedge clk)
  begin : watchdog
    cycles++;
    if (cycles > CYCLE_LIMIT)
      stop_on_error($sformatf("timeout after %0d cycles, the run hung", cycles));
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    int          b;
    int          k;
    logic [31:0] r;
    logic [31:0] w;
    rst_n          = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = lsu_pkg::LSU_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    for (b = 0; b < 64; b++)
    begin
      shadow[b]             = fill_byte(b);
      mem[b/4][8*(b%4) +: 8] = fill_byte(b);
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // aligned words
    run_access("word store 0", 1'b1, lsu_pkg::LSU_WORD, 1'b0, 32'h00, 32'h8badf00d);
    run_access("word store 4", 1'b1, lsu_pkg::LSU_WORD, 1'b0, 32'h04, 32'h7e5a1c33);
    run_access("word load 0", 1'b0, lsu_pkg::LSU_WORD, 1'b0, 32'h00, 32'h0);
    run_access("word load 4", 1'b0, lsu_pkg::LSU_WORD, 1'b1, 32'h04, 32'h0);

    // bytes and halves, each offset, both extensions
    run_access("byte store", 1'b1, lsu_pkg::LSU_BYTE, 1'b0, 32'h21, 32'h000000c3);
    run_access("half store", 1'b1, lsu_pkg::LSU_HALF, 1'b0, 32'h26, 32'h00009a5e);
    for (k = 0; k < 8; k++)
      run_access($sformatf("byte load %0d", k), 1'b0, lsu_pkg::LSU_BYTE, k[0],
                 32'h20 | 32'(k[2:1]), 32'h0);
    for (k = 0; k < 4; k++)
      run_access($sformatf("half load %0d", k), 1'b0, lsu_pkg::LSU_HALF, k[0],
                 32'h24 | 32'({k[1], 1'b0}), 32'h0);

    // words off the boundary, split in two
    for (k = 1; k < 4; k++)
    begin
      run_access($sformatf("split store %0d", k), 1'b1, lsu_pkg::LSU_WORD, 1'b0,
                 32'h2c + 32'(5 * k), 32'hf1e2d3c4 ^ 32'(k));
      run_access($sformatf("split load %0d", k), 1'b0, lsu_pkg::LSU_WORD, 1'b0,
                 32'h2c + 32'(5 * k), 32'h0);
    end

    // half at offset 3
    run_access("half3 store", 1'b1, lsu_pkg::LSU_HALF, 1'b0, 32'h17, 32'h0000beef);
    run_access("half3 load signed", 1'b0, lsu_pkg::LSU_HALF, 1'b1, 32'h17, 32'h0);
    run_access("half3 load unsigned", 1'b0, lsu_pkg::LSU_HALF, 1'b0, 32'h17, 32'h0);

    // random mix, type code 3 included
    for (k = 0; k < 30; k++)
    begin
      r = next_rand();
      w = next_rand();
      run_access($sformatf("random %0d", k), r[0], lsu_pkg::lsu_type_e'(r[2:1]), r[3],
                 {26'd0, r[9:4]}, w);
    end

    repeat (4) @(posedge clk);  // room for a stray done
    #2;
    if (lsu_top_inst.lsu_checker_inst.fail_cnt == 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
      stop_on_error("a protocol assertion in the bound checker failed");
  end

endmodule

//--- build.f
src/lsu_pkg.sv
src/lsu_ctl_if.sv
src/lsu_ctrl.sv
src/lsu_store_fmt.sv
src/lsu_load_align.sv
src/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv
